// ==== Makefile ====
TOP = l2_cache_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
	cat sim.log
	! grep -q "TEST FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
source/l2_cfg_pkg.sv
source/l2_coherence_pkg.sv
source/l2_tag_dir.sv
source/l2_fill_buffer.sv
source/l2_data_array.sv
source/l2_ctrl.sv
source/l2_cache_top.sv
verif/tb_clock.sv
verif/l2_cache_assert.sv
verif/l2_cache_tb.sv

// ==== source/l2_cache_top.sv ====
// L2 cache controller top
`timescale 1ns/1ns

module l2_cache_top #(
  parameter int INDEX_W = 2,
  parameter int BURST_LEN = 8
) (
  input  logic                     stb,
  input  logic                     stb_n,
  input  logic                     req,
  input  logic                     we,
  input  l2_coherence_pkg::snoop_e snoop,
  input  l2_cfg_pkg::addr_t        addr,
  input  l2_cfg_pkg::word_t        wdata,
  output logic                     stall,
  output l2_cfg_pkg::word_t        rdata,
  output logic                     rvalid,
  output logic                     mem_req,
  output l2_cfg_pkg::addr_t        mem_addr,
  input  l2_cfg_pkg::beat_t        mem_beat,
  input  logic                     mem_beat_valid,
  output logic                     wb,
  output l2_cfg_pkg::addr_t        wb_addr
);

  localparam int OFF_W = $clog2(2 * BURST_LEN);
  localparam int TAG_W = l2_cfg_pkg::ADDR_W - INDEX_W - OFF_W - l2_cfg_pkg::BYTE_OFF_W;
  localparam int LINE_W = BURST_LEN * l2_cfg_pkg::BEAT_W;

  // Controller to tag directory
  logic                    lookup;
  logic                    set_state;
  logic [1:0]              set_way;
  l2_coherence_pkg::mesi_e new_state;
  logic                    touch;

  // Lookup results
  logic                    hit;
  logic [1:0]              hit_way;
  l2_coherence_pkg::mesi_e hit_state;
  logic [1:0]              victim_way;
  l2_coherence_pkg::mesi_e victim_state;
  logic [TAG_W-1:0]        victim_tag;

  // Fill path and data array control
  logic              line_ready;
  logic [LINE_W-1:0] line;
  logic              rd;
  logic              wr;
  logic              line_wr;
  logic [1:0]        way;

  l2_ctrl #(.INDEX_W(INDEX_W), .BURST_LEN(BURST_LEN)) ctrl_i (
    .stb(stb), .stb_n(stb_n), .req(req), .we(we), .snoop(snoop), .addr(addr),
    .hit(hit), .hit_way(hit_way), .hit_state(hit_state),
    .victim_way(victim_way), .victim_state(victim_state), .victim_tag(victim_tag),
    .line_ready(line_ready), .lookup(lookup), .set_state(set_state), .set_way(set_way),
    .new_state(new_state), .touch(touch), .rd(rd), .wr(wr), .line_wr(line_wr), .way(way),
    .stall(stall), .rvalid(rvalid), .mem_req(mem_req), .mem_addr(mem_addr),
    .wb(wb), .wb_addr(wb_addr)
  );

  l2_tag_dir #(.INDEX_W(INDEX_W), .BURST_LEN(BURST_LEN)) tag_dir_i (
    .stb(stb), .stb_n(stb_n), .lookup(lookup), .addr(addr),
    .set_state(set_state), .set_way(set_way), .new_state(new_state), .touch(touch),
    .hit(hit), .hit_way(hit_way), .hit_state(hit_state),
    .victim_way(victim_way), .victim_state(victim_state), .victim_tag(victim_tag)
  );

  // Memory beats feed the buffer directly
  l2_fill_buffer #(.BURST_LEN(BURST_LEN)) fill_buf_i (
    .stb(stb), .stb_n(stb_n), .mem_beat(mem_beat), .mem_beat_valid(mem_beat_valid),
    .line_ready(line_ready), .line(line)
  );

  // L1 keeps addr and wdata steady while stall is high
  l2_data_array #(.INDEX_W(INDEX_W), .BURST_LEN(BURST_LEN)) data_i (
    .stb(stb), .stb_n(stb_n), .addr(addr), .way(way), .rd(rd), .wr(wr),
    .wdata(wdata), .line_wr(line_wr), .line(line), .rdata(rdata)
  );

endmodule

// ==== source/l2_cfg_pkg.sv ====
// L2 cache bus widths
package l2_cfg_pkg;

  // Byte address on the L1 side
  localparam int ADDR_W = 32;

  // One L1 data word
  localparam int WORD_W = 32;

  // One memory burst beat holds two words
  localparam int BEAT_W = 64;

  // Byte select bits below the word offset
  localparam int BYTE_OFF_W = 2;

  // Byte address
  typedef logic [ADDR_W-1:0] addr_t;

  // L1 data word
  typedef logic [WORD_W-1:0] word_t;

  // Memory beat with the even word in the low half
  typedef logic [BEAT_W-1:0] beat_t;

endpackage

// ==== source/l2_coherence_pkg.sv ====
// L2 coherence and control encodings
package l2_coherence_pkg;

  // MESI state of one line
  typedef enum logic [1:0] {
    INVALID   = 2'b00,
    EXCLUSIVE = 2'b01,
    SHARED    = 2'b10,
    MODIFIED  = 2'b11
  } mesi_e;

  // Upper bit set marks a snooped request
  typedef enum logic [1:0] {
    LOCAL_ACCESS = 2'b00,
    LOCAL_ALT    = 2'b01,
    SNOOP_RD     = 2'b10,
    SNOOP_WR     = 2'b11
  } snoop_e;

  // Request sequencing states
  typedef enum logic [2:0] {IDLE, LOOKUP, FILL, WRITE_LINE, RESPOND, SNOOP} ctrl_state_e;

  // Tree bits of one 4-way set
  typedef logic [2:0] plru_t;

endpackage

// ==== source/l2_ctrl.sv ====
// L2 request sequencer
`timescale 1ns/1ns

module l2_ctrl #(
  parameter int INDEX_W = 2,
  parameter int BURST_LEN = 8,
  localparam int OFF_W = $clog2(2 * BURST_LEN),
  localparam int TAG_W = l2_cfg_pkg::ADDR_W - INDEX_W - OFF_W - l2_cfg_pkg::BYTE_OFF_W
) (
  input  logic                     stb,
  input  logic                     stb_n,
  input  logic                     req,
  input  logic                     we,
  input  l2_coherence_pkg::snoop_e snoop,
  input  l2_cfg_pkg::addr_t        addr,
  input  logic                     hit,
  input  logic [1:0]               hit_way,
  input  l2_coherence_pkg::mesi_e  hit_state,
  input  logic [1:0]               victim_way,
  input  l2_coherence_pkg::mesi_e  victim_state,
  input  logic [TAG_W-1:0]         victim_tag,
  input  logic                     line_ready,
  output logic                     lookup,
  output logic                     set_state,
  output logic [1:0]               set_way,
  output l2_coherence_pkg::mesi_e  new_state,
  output logic                     touch,
  output logic                     rd,
  output logic                     wr,
  output logic                     line_wr,
  output logic [1:0]               way,
  output logic                     stall,
  output logic                     rvalid,
  output logic                     mem_req,
  output l2_cfg_pkg::addr_t        mem_addr,
  output logic                     wb,
  output l2_cfg_pkg::addr_t        wb_addr
);

  // Lowest bit above the line offset
  localparam int LINE_LSB = l2_cfg_pkg::BYTE_OFF_W + OFF_W;

  l2_coherence_pkg::ctrl_state_e state;
  l2_coherence_pkg::ctrl_state_e state_nx;

  // Request as captured with req
  logic                     req_we;
  l2_coherence_pkg::snoop_e req_snoop;
  l2_cfg_pkg::addr_t        req_addr;

  // First cycle of a miss
  logic miss_start;

  logic [INDEX_W-1:0] req_set;
  l2_cfg_pkg::addr_t  req_line;
  l2_cfg_pkg::addr_t  victim_line;

  assign req_set     = req_addr[LINE_LSB +: INDEX_W];
  assign req_line    = {req_addr[l2_cfg_pkg::ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
  // Evicted line rebuilt from its stored tag
  assign victim_line = {victim_tag, req_set, {LINE_LSB{1'b0}}};

  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      state      <= l2_coherence_pkg::IDLE;
      miss_start <= 1'b0;
    end
    else
    begin
      state      <= state_nx;
      miss_start <= (state == l2_coherence_pkg::LOOKUP) && (state_nx == l2_coherence_pkg::FILL);
    end
  end

  always_ff @(posedge stb)
  begin
    if (state == l2_coherence_pkg::IDLE && req)
    begin
      req_we    <= we;
      req_snoop <= snoop;
      req_addr  <= addr;
    end
  end

  // Busy in every state but idle
  assign stall   = (state != l2_coherence_pkg::IDLE);
  assign rvalid  = (state == l2_coherence_pkg::RESPOND) && !req_we;
  assign mem_req = miss_start;
  assign mem_addr = req_line;

  // Snooped dirty line or dirty victim on a miss
  assign wb = (state == l2_coherence_pkg::SNOOP)
              ? (hit && hit_state == l2_coherence_pkg::MODIFIED)
              : (miss_start && victim_state == l2_coherence_pkg::MODIFIED);
  assign wb_addr = (state == l2_coherence_pkg::SNOOP) ? req_line : victim_line;

  // Tag directory and data array share the way select
  assign set_way = way;

  always_comb
  begin
    state_nx  = state;
    lookup    = 1'b0;
    set_state = 1'b0;
    new_state = hit_state;
    touch     = 1'b0;
    rd        = 1'b0;
    wr        = 1'b0;
    line_wr   = 1'b0;
    // Fills target the victim
    way = (state == l2_coherence_pkg::WRITE_LINE) ? victim_way : hit_way;
    case (state)
      l2_coherence_pkg::IDLE:
      begin
        if (req)
        begin
          lookup   = 1'b1;
          state_nx = l2_coherence_pkg::LOOKUP;
        end
      end
      l2_coherence_pkg::LOOKUP:
      begin
        if (req_snoop[1])
          state_nx = l2_coherence_pkg::SNOOP;
        else if (hit)
        begin
          // Local hit serviced in place
          rd        = !req_we;
          wr        = req_we;
          set_state = req_we;
          new_state = l2_coherence_pkg::MODIFIED;
          touch     = 1'b1;
          state_nx  = l2_coherence_pkg::RESPOND;
        end
        else
          state_nx = l2_coherence_pkg::FILL;
      end
      l2_coherence_pkg::FILL:
      begin
        // Beats may arrive with gaps
        if (line_ready)
          state_nx = l2_coherence_pkg::WRITE_LINE;
      end
      l2_coherence_pkg::WRITE_LINE:
      begin
        line_wr   = 1'b1;
        rd        = !req_we;
        wr        = req_we;
        set_state = 1'b1;
        new_state = req_we ? l2_coherence_pkg::MODIFIED : l2_coherence_pkg::EXCLUSIVE;
        touch     = 1'b1;
        state_nx  = l2_coherence_pkg::RESPOND;
      end
      l2_coherence_pkg::RESPOND:
        state_nx = l2_coherence_pkg::IDLE;
      l2_coherence_pkg::SNOOP:
      begin
        // No fill and no tree update on snoops
        set_state = hit;
        new_state = (req_snoop == l2_coherence_pkg::SNOOP_WR) ? l2_coherence_pkg::INVALID
                                                             : l2_coherence_pkg::SHARED;
        state_nx  = l2_coherence_pkg::IDLE;
      end
      default:
        state_nx = l2_coherence_pkg::IDLE;
    endcase
  end

endmodule

// ==== source/l2_data_array.sv ====
// L2 line data storage
`timescale 1ns/1ns

module l2_data_array #(
  parameter int INDEX_W = 2,
  parameter int BURST_LEN = 8,
  localparam int WORDS = 2 * BURST_LEN,
  localparam int LINE_W = WORDS * l2_cfg_pkg::WORD_W
) (
  input  logic              stb,
  input  logic              stb_n,
  input  l2_cfg_pkg::addr_t addr,
  input  logic [1:0]        way,
  input  logic              rd,
  input  logic              wr,
  input  l2_cfg_pkg::word_t wdata,
  input  logic              line_wr,
  input  logic [LINE_W-1:0] line,
  output l2_cfg_pkg::word_t rdata
);

  localparam int OFF_W = $clog2(WORDS);

  // Word storage per way, set and word
  l2_cfg_pkg::word_t data_mem [4][1 << INDEX_W][WORDS];

  logic [OFF_W-1:0]   word_sel;
  logic [INDEX_W-1:0] set_sel;

  assign word_sel = addr[l2_cfg_pkg::BYTE_OFF_W +: OFF_W];
  assign set_sel  = addr[l2_cfg_pkg::BYTE_OFF_W + OFF_W +: INDEX_W];

  always_ff @(posedge stb)
  begin
    // Whole line from the fill buffer
    if (line_wr)
    begin
      for (int w = 0; w < WORDS; w++)
        data_mem[way][set_sel][w] <= line[w * l2_cfg_pkg::WORD_W +: l2_cfg_pkg::WORD_W];
    end
    // Word write comes last so it merges over a fill
    if (wr)
      data_mem[way][set_sel][word_sel] <= wdata;
  end

  // Reads during a fill see the incoming line
  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
      rdata <= '0;
    else if (rd)
      rdata <= line_wr ? line[word_sel * l2_cfg_pkg::WORD_W +: l2_cfg_pkg::WORD_W]
                       : data_mem[way][set_sel][word_sel];
  end

endmodule

// ==== source/l2_fill_buffer.sv ====
// L2 line fill buffer
`timescale 1ns/1ns

module l2_fill_buffer #(
  parameter int BURST_LEN = 8,
  localparam int LINE_W = BURST_LEN * l2_cfg_pkg::BEAT_W
) (
  input  logic              stb,
  input  logic              stb_n,
  input  l2_cfg_pkg::beat_t mem_beat,
  input  logic              mem_beat_valid,
  output logic              line_ready,
  output logic [LINE_W-1:0] line
);

  localparam int CNT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;

  // Position of the next beat in the line
  logic [CNT_W-1:0] beat_cnt;
  logic             last_beat;

  assign last_beat = (beat_cnt == CNT_W'(BURST_LEN - 1));

  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      beat_cnt   <= '0;
      line_ready <= 1'b0;
    end
    else
    begin
      // One cycle after the final beat
      line_ready <= mem_beat_valid && last_beat;
      // Gaps between beats just hold the count
      if (mem_beat_valid)
        beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
    end
  end

  // Beat n lands on words 2n and 2n+1
  always_ff @(posedge stb)
  begin
    if (mem_beat_valid)
      line[beat_cnt * l2_cfg_pkg::BEAT_W +: l2_cfg_pkg::BEAT_W] <= mem_beat;
  end

endmodule

// ==== source/l2_tag_dir.sv ====
// L2 tag and MESI directory
`timescale 1ns/1ns

module l2_tag_dir #(
  parameter int INDEX_W = 2,
  parameter int BURST_LEN = 8,
  localparam int OFF_W = $clog2(2 * BURST_LEN),
  localparam int TAG_W = l2_cfg_pkg::ADDR_W - INDEX_W - OFF_W - l2_cfg_pkg::BYTE_OFF_W
) (
  input  logic                    stb,
  input  logic                    stb_n,
  input  logic                    lookup,
  input  l2_cfg_pkg::addr_t       addr,
  input  logic                    set_state,
  input  logic [1:0]              set_way,
  input  l2_coherence_pkg::mesi_e new_state,
  input  logic                    touch,
  output logic                    hit,
  output logic [1:0]              hit_way,
  output l2_coherence_pkg::mesi_e hit_state,
  output logic [1:0]              victim_way,
  output l2_coherence_pkg::mesi_e victim_state,
  output logic [TAG_W-1:0]        victim_tag
);

  localparam int SETS = 1 << INDEX_W;

  // Directory storage per way and set
  logic [TAG_W-1:0]        tag_mem   [4][SETS];
  l2_coherence_pkg::mesi_e state_mem [4][SETS];
  l2_coherence_pkg::plru_t plru_mem  [SETS];

  // Set and tag of the request being looked up
  logic [INDEX_W-1:0]      in_set;
  logic [TAG_W-1:0]        in_tag;
  l2_coherence_pkg::plru_t plru_cur;

  // Held from the last lookup for later updates
  logic [INDEX_W-1:0] lk_set;
  logic [TAG_W-1:0]   lk_tag;

  logic       hit_d;
  logic [1:0] hit_way_d;
  logic [1:0] victim_d;

  assign in_set   = addr[l2_cfg_pkg::BYTE_OFF_W + OFF_W +: INDEX_W];
  assign in_tag   = addr[l2_cfg_pkg::ADDR_W-1 -: TAG_W];
  assign plru_cur = plru_mem[in_set];

  // Tag compare against every valid way
  always_comb
  begin
    hit_d     = 1'b0;
    hit_way_d = 2'd0;
    for (int w = 0; w < 4; w++)
    begin
      if (state_mem[w][in_set] != l2_coherence_pkg::INVALID && tag_mem[w][in_set] == in_tag)
      begin
        hit_d     = 1'b1;
        hit_way_d = 2'(w);
      end
    end
  end

  // Tree walk first
  always_comb
  begin
    if (!plru_cur[2])
      victim_d = plru_cur[1] ? 2'd1 : 2'd0;
    else
      victim_d = plru_cur[0] ? 2'd3 : 2'd2;
    // Any empty way overrides the tree
    // Downward scan leaves the lowest empty way
    for (int w = 3; w >= 0; w--)
    begin
      if (state_mem[w][in_set] == l2_coherence_pkg::INVALID)
        victim_d = 2'(w);
    end
  end

  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
      hit <= 1'b0;
    else if (lookup)
      hit <= hit_d;
  end

  // Lookup results stay put until the next lookup
  always_ff @(posedge stb)
  begin
    if (lookup)
    begin
      lk_set       <= in_set;
      lk_tag       <= in_tag;
      hit_way      <= hit_way_d;
      hit_state    <= state_mem[hit_way_d][in_set];
      victim_way   <= victim_d;
      victim_state <= state_mem[victim_d][in_set];
      victim_tag   <= tag_mem[victim_d][in_set];
    end
  end

  always_ff @(posedge stb)
  begin
    if (set_state)
      tag_mem[set_way][lk_set] <= lk_tag;
  end

  // Line states and tree bits
  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      for (int s = 0; s < SETS; s++)
      begin
        plru_mem[s] <= '0;
        for (int w = 0; w < 4; w++)
          state_mem[w][s] <= l2_coherence_pkg::INVALID;
      end
    end
    else
    begin
      if (set_state)
        state_mem[set_way][lk_set] <= new_state;
      // Point the tree away from the accessed way
      if (touch)
      begin
        case (set_way)
          2'd0:
          begin
            plru_mem[lk_set][2] <= 1'b1;
            plru_mem[lk_set][1] <= 1'b1;
          end
          2'd1:
          begin
            plru_mem[lk_set][2] <= 1'b1;
            plru_mem[lk_set][1] <= 1'b0;
          end
          2'd2:
          begin
            plru_mem[lk_set][2] <= 1'b0;
            plru_mem[lk_set][0] <= 1'b1;
          end
          default:
          begin
            plru_mem[lk_set][2] <= 1'b0;
            plru_mem[lk_set][0] <= 1'b0;
          end
        endcase
      end
    end
  end

endmodule

// ==== verif/l2_cache_assert.sv ====
// L2 cache interface assertions
`timescale 1ns/1ns

module l2_cache_assert #(
  parameter int BURST_LEN = 8,
  localparam int LINE_LSB = l2_cfg_pkg::BYTE_OFF_W + $clog2(2 * BURST_LEN)
) (
  input logic              stb,
  input logic              stb_n,
  input logic              stall,
  input logic              rvalid,
  input logic              mem_req,
  input l2_cfg_pkg::addr_t mem_addr,
  input logic              wb
);

  // Read data only inside a request
  rvalid_in_stall: assert property (@(posedge stb) disable iff (!stb_n) rvalid |-> stall)
    else $error("rvalid seen while stall is low");

  // Refill requests only inside a request
  mem_req_in_stall: assert property (@(posedge stb) disable iff (!stb_n) mem_req |-> stall)
    else $error("mem_req seen while stall is low");

  // Refill address points at a line start
  mem_addr_aligned: assert property (@(posedge stb) disable iff (!stb_n)
    mem_req |-> (mem_addr[LINE_LSB-1:0] == '0))
    else $error("mem_addr not line aligned");

  // Write-back and read response never share a cycle
  wb_not_rvalid: assert property (@(posedge stb) disable iff (!stb_n) !(wb && rvalid))
    else $error("wb and rvalid in the same cycle");

endmodule

bind l2_cache_top l2_cache_assert #(.BURST_LEN(BURST_LEN)) assert_i (
  .stb(stb),
  .stb_n(stb_n),
  .stall(stall),
  .rvalid(rvalid),
  .mem_req(mem_req),
  .mem_addr(mem_addr),
  .wb(wb)
);

// ==== verif/l2_cache_tb.sv ====
// L2 cache directed testbench
`timescale 1ns/1ns

module l2_cache_tb;

  localparam int INDEX_W = 2;
  localparam int BURST_LEN = 8;
  localparam int LINE_BYTES = 2 * BURST_LEN * 4;
  localparam int SETS = 1 << INDEX_W;
  localparam int NUM_TESTS = 5;
  // Upper bound on one request including a refill
  localparam int REQ_LIMIT = 100;

  logic                     stb;
  logic                     stb_n;
  logic                     req;
  logic                     we;
  l2_coherence_pkg::snoop_e snoop;
  l2_cfg_pkg::addr_t        addr;
  l2_cfg_pkg::word_t        wdata;
  logic                     stall;
  l2_cfg_pkg::word_t        rdata;
  logic                     rvalid;
  logic                     mem_req;
  l2_cfg_pkg::addr_t        mem_addr;
  l2_cfg_pkg::beat_t        mem_beat;
  logic                     mem_beat_valid;
  logic                     wb;
  l2_cfg_pkg::addr_t        wb_addr;

  // Seen during the last request
  int                rvalid_cnt;
  int                mem_req_cnt;
  int                wb_cnt;
  l2_cfg_pkg::word_t seen_rdata;
  l2_cfg_pkg::addr_t seen_mem_addr;
  l2_cfg_pkg::addr_t seen_wb_addr;

  int errors;
  int failed_tests;
  int err_mark;

  // Reference model of the set used for replacement
  logic       m_valid [4];
  logic       m_dirty [4];
  int         m_tag   [4];
  logic [2:0] m_plru;

  tb_clock clk_i (.stb(stb), .stb_n(stb_n));

  l2_cache_top #(.INDEX_W(INDEX_W), .BURST_LEN(BURST_LEN)) dut_i (
    .stb(stb), .stb_n(stb_n), .req(req), .we(we), .snoop(snoop), .addr(addr),
    .wdata(wdata), .stall(stall), .rdata(rdata), .rvalid(rvalid), .mem_req(mem_req),
    .mem_addr(mem_addr), .mem_beat(mem_beat), .mem_beat_valid(mem_beat_valid),
    .wb(wb), .wb_addr(wb_addr)
  );

  function automatic l2_cfg_pkg::addr_t line_of(input l2_cfg_pkg::addr_t a);
    line_of = a & ~l2_cfg_pkg::addr_t'(LINE_BYTES - 1);
  endfunction

  // Tag, set and byte offset into one address
  function automatic l2_cfg_pkg::addr_t make_addr(input int tag, input int set, input int off);
    make_addr = l2_cfg_pkg::addr_t'(tag * SETS * LINE_BYTES + set * LINE_BYTES + off);
  endfunction

  // Memory model where every word holds its own byte address
  initial
  begin
    l2_cfg_pkg::addr_t base;
    int                gap;
    void'($urandom(32'heeed2dbe));
    mem_beat = '0;
    mem_beat_valid = 1'b0;
    forever
    begin
      @(negedge stb);
      if (mem_req === 1'b1)
      begin
        base = mem_addr;
        gap = int'($urandom % 4);
        repeat (gap) @(posedge stb);
        for (int n = 0; n < BURST_LEN; n++)
        begin
          @(posedge stb);
          // Even word in the low half
          mem_beat <= {l2_cfg_pkg::word_t'(base + 8 * n + 4), l2_cfg_pkg::word_t'(base + 8 * n)};
          mem_beat_valid <= 1'b1;
        end
        @(posedge stb);
        mem_beat_valid <= 1'b0;
      end
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // One request held until stall drops
  task automatic access(input logic w, input l2_coherence_pkg::snoop_e sn,
                        input l2_cfg_pkg::addr_t a, input l2_cfg_pkg::word_t d);
    int cycles;
    rvalid_cnt = 0;
    mem_req_cnt = 0;
    wb_cnt = 0;
    cycles = 0;
    @(posedge stb);
    req <= 1'b1;
    we <= w;
    snoop <= sn;
    addr <= a;
    wdata <= d;
    @(posedge stb);
    req <= 1'b0;
    do
    begin
      @(negedge stb);
      if (rvalid)
      begin
        rvalid_cnt++;
        seen_rdata = rdata;
      end
      if (mem_req)
      begin
        mem_req_cnt++;
        seen_mem_addr = mem_addr;
      end
      if (wb)
      begin
        wb_cnt++;
        seen_wb_addr = wb_addr;
      end
      cycles++;
    end
    while (stall && cycles < REQ_LIMIT);
    if (stall)
    begin
      $display("Request to address %h did not complete in %0d cycles", a, REQ_LIMIT);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark)
      $display("%s: passed", name);
    else
    begin
      failed_tests++;
      $display("%s: failed with %0d errors", name, errors - err_mark);
    end
  endtask

  task automatic read_miss_then_hit();
    l2_cfg_pkg::addr_t a0;
    l2_cfg_pkg::addr_t a1;
    err_mark = errors;
    a0 = make_addr(16, 0, 4);
    a1 = make_addr(16, 0, 56);
    access(1'b0, l2_coherence_pkg::LOCAL_ACCESS, a0, '0);
    check_val("rvalid count", rvalid_cnt, 1);
    check_val("rdata", seen_rdata, a0);
    check_val("mem_req count", mem_req_cnt, 1);
    check_val("mem_addr", seen_mem_addr, line_of(a0));
    // Other word of the same line
    access(1'b0, l2_coherence_pkg::LOCAL_ACCESS, a1, '0);
    check_val("rvalid count", rvalid_cnt, 1);
    check_val("rdata", seen_rdata, a1);
    check_val("mem_req count", mem_req_cnt, 0);
    end_test("read miss then hit");
  endtask

  task automatic write_hit_then_read();
    l2_cfg_pkg::addr_t a;
    err_mark = errors;
    a = make_addr(16, 0, 8);
    access(1'b1, l2_coherence_pkg::LOCAL_ACCESS, a, 32'hcafe_0001);
    check_val("rvalid count", rvalid_cnt, 0);
    check_val("mem_req count", mem_req_cnt, 0);
    access(1'b0, l2_coherence_pkg::LOCAL_ACCESS, a, '0);
    check_val("rdata", seen_rdata, 32'hcafe_0001);
    check_val("mem_req count", mem_req_cnt, 0);
    end_test("write hit then read");
  endtask

  task automatic write_miss_merge();
    l2_cfg_pkg::addr_t a;
    l2_cfg_pkg::addr_t b;
    err_mark = errors;
    a = make_addr(32, 1, 4);
    b = make_addr(32, 1, 20);
    access(1'b1, l2_coherence_pkg::LOCAL_ACCESS, a, 32'h1234_5678);
    check_val("mem_req count", mem_req_cnt, 1);
    check_val("mem_addr", seen_mem_addr, line_of(a));
    check_val("wb count", wb_cnt, 0);
    // Written word merged over the fill
    access(1'b0, l2_coherence_pkg::LOCAL_ACCESS, a, '0);
    check_val("rdata", seen_rdata, 32'h1234_5678);
    check_val("mem_req count", mem_req_cnt, 0);
    access(1'b0, l2_coherence_pkg::LOCAL_ACCESS, b, '0);
    check_val("rdata", seen_rdata, b);
    check_val("mem_req count", mem_req_cnt, 0);
    end_test("write miss");
  endtask

  // Lowest empty way first, then the tree
  function automatic int pick_victim();
    for (int i = 0; i < 4; i++)
    begin
      if (!m_valid[i])
        return i;
    end
    if (!m_plru[2])
      return m_plru[1] ? 1 : 0;
    return m_plru[0] ? 3 : 2;
  endfunction

  function automatic void plru_touch(input int way);
    if (way < 2)
    begin
      m_plru[2] = 1'b1;
      m_plru[1] = (way == 0);
    end
    else
    begin
      m_plru[2] = 1'b0;
      m_plru[0] = (way == 2);
    end
  endfunction

  // Access in set 2 checked against the predicted hit or eviction
  task automatic rep_access(input int tag, input logic w);
    l2_cfg_pkg::addr_t a;
    int                hw;
    int                vw;
    logic              exp_wb;
    a = make_addr(tag, 2, w ? 4 : 0);
    hw = -1;
    for (int i = 0; i < 4; i++)
    begin
      if (m_valid[i] && m_tag[i] == tag)
        hw = i;
    end
    access(w, l2_coherence_pkg::LOCAL_ACCESS, a, 32'hd000_0000 + tag);
    if (hw >= 0)
    begin
      check_val("mem_req count", mem_req_cnt, 0);
      check_val("wb count", wb_cnt, 0);
      m_dirty[hw] = m_dirty[hw] | w;
      plru_touch(hw);
    end
    else
    begin
      vw = pick_victim();
      exp_wb = m_valid[vw] && m_dirty[vw];
      check_val("mem_req count", mem_req_cnt, 1);
      check_val("mem_addr", seen_mem_addr, line_of(a));
      check_val("wb count", wb_cnt, 32'(exp_wb));
      if (exp_wb)
        check_val("wb_addr", seen_wb_addr, make_addr(m_tag[vw], 2, 0));
      m_valid[vw] = 1'b1;
      m_dirty[vw] = w;
      m_tag[vw] = tag;
      plru_touch(vw);
    end
    if (!w)
      check_val("rdata", seen_rdata, a);
  endtask

  task automatic replacement_order();
    err_mark = errors;
    for (int i = 0; i < 4; i++)
    begin
      m_valid[i] = 1'b0;
      m_dirty[i] = 1'b0;
      m_tag[i] = -1;
    end
    m_plru = 3'b000;
    // Fill all four ways, then refresh tag 0
    for (int t = 0; t < 4; t++)
      rep_access(48 + t, 1'b0);
    rep_access(48, 1'b0);
    // Fifth tag evicts one clean line
    rep_access(52, 1'b0);
    rep_access(48, 1'b0);
    rep_access(49, 1'b0);
    rep_access(51, 1'b0);
    rep_access(52, 1'b0);
    rep_access(50, 1'b0);
    // Dirty every line so the next eviction writes back
    for (int i = 0; i < 4; i++)
      rep_access(m_tag[i], 1'b1);
    rep_access(53, 1'b0);
    end_test("replacement");
  endtask

  task automatic snoop_states();
    l2_cfg_pkg::addr_t a;
    l2_cfg_pkg::addr_t b;
    err_mark = errors;
    a = make_addr(64, 3, 4);
    b = make_addr(80, 3, 0);
    access(1'b1, l2_coherence_pkg::LOCAL_ACCESS, a, 32'h5a5a_0005);
    check_val("mem_req count", mem_req_cnt, 1);
    // Dirty line written back and then shared
    access(1'b0, l2_coherence_pkg::SNOOP_RD, a, '0);
    check_val("wb count", wb_cnt, 1);
    check_val("wb_addr", seen_wb_addr, line_of(a));
    check_val("mem_req count", mem_req_cnt, 0);
    check_val("rvalid count", rvalid_cnt, 0);
    access(1'b0, l2_coherence_pkg::SNOOP_RD, line_of(a), '0);
    check_val("wb count", wb_cnt, 0);
    access(1'b0, l2_coherence_pkg::SNOOP_WR, line_of(a), '0);
    check_val("wb count", wb_cnt, 0);
    // Invalidated line refetched from memory
    access(1'b0, l2_coherence_pkg::LOCAL_ACCESS, a, '0);
    check_val("mem_req count", mem_req_cnt, 1);
    check_val("rdata", seen_rdata, a);
    access(1'b0, l2_coherence_pkg::SNOOP_RD, b, '0);
    check_val("wb count", wb_cnt, 0);
    check_val("mem_req count", mem_req_cnt, 0);
    access(1'b0, l2_coherence_pkg::SNOOP_WR, b, '0);
    check_val("wb count", wb_cnt, 0);
    check_val("mem_req count", mem_req_cnt, 0);
    end_test("snooping");
  endtask

  initial
  begin
    errors = 0;
    failed_tests = 0;
    req = 1'b0;
    we = 1'b0;
    snoop = l2_coherence_pkg::LOCAL_ACCESS;
    addr = '0;
    wdata = '0;
    wait (stb_n === 1'b1);
    repeat (2) @(posedge stb);
    read_miss_then_hit();
    write_hit_then_read();
    write_miss_merge();
    replacement_order();
    snoop_states();
    $display("Summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Watchdog sized from the test count
  initial
  begin
    repeat (NUM_TESTS * 200) @(posedge stb);
    $display("Timeout after %0d cycles, the tests did not finish", NUM_TESTS * 200);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== verif/tb_clock.sv ====
// Testbench clock and reset
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic stb,
  output logic stb_n
);

  // Free running clock
  initial
  begin
    stb = 1'b0;
    forever #(PERIOD / 2) stb = ~stb;
  end

  // Reset low for the first cycles and released on an edge
  initial
  begin
    stb_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge stb);
    stb_n <= 1'b1;
  end

endmodule
